/* hw/axis_reg_array.sv */
// Chain of register slices of configurable depth
// Zero stages leaves a plain combinational path

`timescale 1ns/1ps

module axis_reg_array import net_pkg::*; #(
    parameter int N_STAGES = PIPE_STAGES
) (
    input  logic                     aclk,
    input  logic                     aresetn,

    // Upstream
    input  logic                     s_tvalid,
    output logic                     s_tready,
    input  logic [NET_DATA_BITS-1:0] s_tdata,
    input  logic [NET_KEEP_BITS-1:0] s_tkeep,
    input  logic                     s_tlast,

    // Downstream
    output logic                     m_tvalid,
    input  logic                     m_tready,
    output logic [NET_DATA_BITS-1:0] m_tdata,
    output logic [NET_KEEP_BITS-1:0] m_tkeep,
    output logic                     m_tlast
);

    if (N_STAGES == 0) begin : gen_pass
        // No registers, stream goes straight through
        assign m_tvalid = s_tvalid;
        assign s_tready = m_tready;
        assign m_tdata  = s_tdata;
        assign m_tkeep  = s_tkeep;
        assign m_tlast  = s_tlast;
    end else begin : gen_chain
        // Index 0 is the array input, N_STAGES the output
        wire [N_STAGES:0]          vld;
        wire [N_STAGES:0]          rdy;
        wire [N_STAGES:0]          lst;
        wire [NET_DATA_BITS-1:0]   dat [N_STAGES+1];
        wire [NET_KEEP_BITS-1:0]   kep [N_STAGES+1];

        assign vld[0]   = s_tvalid;
        assign dat[0]   = s_tdata;
        assign kep[0]   = s_tkeep;
        assign lst[0]   = s_tlast;
        assign s_tready = rdy[0];

        for (genvar i = 0; i < N_STAGES; i++) begin : gen_stage
            axis_reg_slice inst_slice (
                .aclk     (aclk),
                .aresetn  (aresetn),
                .s_tvalid (vld[i]),
                .s_tready (rdy[i]),
                .s_tdata  (dat[i]),
                .s_tkeep  (kep[i]),
                .s_tlast  (lst[i]),
                .m_tvalid (vld[i+1]),
                .m_tready (rdy[i+1]),
                .m_tdata  (dat[i+1]),
                .m_tkeep  (kep[i+1]),
                .m_tlast  (lst[i+1])
            );
        end

        // Last stage faces the sink
        assign m_tvalid         = vld[N_STAGES];
        assign rdy[N_STAGES]    = m_tready;
        assign m_tdata          = dat[N_STAGES];
        assign m_tkeep          = kep[N_STAGES];
        assign m_tlast          = lst[N_STAGES];
    end

endmodule

/* hw/axis_reg_slice.sv */
// Single register slice for a data/keep/last beat stream
// Holds one beat; takes a new one when empty or when draining

`timescale 1ns/1ps

module axis_reg_slice import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,

    // Upstream
    input  logic                     s_tvalid,
    output logic                     s_tready,
    input  logic [NET_DATA_BITS-1:0] s_tdata,
    input  logic [NET_KEEP_BITS-1:0] s_tkeep,
    input  logic                     s_tlast,

    // Downstream
    output logic                     m_tvalid,
    input  logic                     m_tready,
    output logic [NET_DATA_BITS-1:0] m_tdata,
    output logic [NET_KEEP_BITS-1:0] m_tkeep,
    output logic                     m_tlast
);

    // Free slot, or current beat leaves this cycle
    assign s_tready = !m_tvalid || m_tready;

    // Occupancy flag
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_tvalid <= 1'b0;
        end else if (s_tready) begin
            m_tvalid <= s_tvalid;
        end
    end

    // Payload, loaded on every accepted beat
    always_ff @(posedge aclk) begin
        if (s_tready && s_tvalid) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
        end
    end

    // Stalled beat must not change under the sink
    a_hold_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_tvalid && !m_tready |=> $stable(m_tdata)
    );

endmodule

/* hw/net_bp_drop.sv */
// Per-packet drop filter on the network RX stream
// Keeps or discards each packet whole, decided at its first beat
// from the programmable-full flag of the RX FIFO; never stalls

`timescale 1ns/1ps

module net_bp_drop import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,

    // Level flag from the RX FIFO
    input  logic                     prog_full,

    // Network side has no ready
    input  logic                     s_tvalid,
    input  logic [NET_DATA_BITS-1:0] s_tdata,
    input  logic [NET_KEEP_BITS-1:0] s_tkeep,
    input  logic                     s_tlast,

    // Filtered stream is a strobe only
    output logic                     m_tvalid,
    output logic [NET_DATA_BITS-1:0] m_tdata,
    output logic [NET_KEEP_BITS-1:0] m_tkeep,
    output logic                     m_tlast
);

    // Idle waits for a first beat; fwd and drop last until tlast
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_FWD  = 2'b01,
        ST_DROP = 2'b10
    } state_t;

    state_t state_c;
    state_t state_n;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_c <= ST_IDLE;
        end else begin
            state_c <= state_n;
        end
    end

    // Next state
    always_comb begin
        state_n = state_c;
        case (state_c)
            ST_IDLE: begin
                // Single-beat packets never leave idle
                if (s_tvalid && !s_tlast) begin
                    state_n = prog_full ? ST_DROP : ST_FWD;
                end
            end
            ST_FWD, ST_DROP: begin
                if (s_tvalid && s_tlast) begin
                    state_n = ST_IDLE;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    // Mask valid by state, with the live flag on a first beat
    always_comb begin
        case (state_c)
            ST_IDLE: m_tvalid = s_tvalid && !prog_full;
            ST_FWD:  m_tvalid = s_tvalid;
            default: m_tvalid = 1'b0;
        endcase
    end

    // Payload is never altered
    assign m_tdata = s_tdata;
    assign m_tkeep = s_tkeep;
    assign m_tlast = s_tlast;

    // Beat after a non-last beat shares its keep or drop outcome
    a_whole_packet: assert property (
        @(posedge aclk) disable iff (!aresetn)
        s_tvalid && !s_tlast |=> !s_tvalid || (m_tvalid == $past(m_tvalid))
    );

endmodule

/* hw/net_ingress_top.sv */
// Network ingress stage
// RX: drop filter, register slices, receive FIFO towards the host
// TX: register slices only

`timescale 1ns/1ps

module net_ingress_top import net_pkg::*; (
    input  logic                        aclk,
    input  logic                        aresetn,

    // Network RX, always accepted
    input  logic                        s_rx_tvalid,
    input  logic [NET_DATA_BITS-1:0]    s_rx_tdata,
    input  logic [NET_KEEP_BITS-1:0]    s_rx_tkeep,
    input  logic                        s_rx_tlast,

    // Host RX
    output logic                        m_rx_tvalid,
    input  logic                        m_rx_tready,
    output logic [NET_DATA_BITS-1:0]    m_rx_tdata,
    output logic [NET_KEEP_BITS-1:0]    m_rx_tkeep,
    output logic                        m_rx_tlast,

    // TX pass-through in
    input  logic                        s_tx_tvalid,
    output logic                        s_tx_tready,
    input  logic [NET_DATA_BITS-1:0]    s_tx_tdata,
    input  logic [NET_KEEP_BITS-1:0]    s_tx_tkeep,
    input  logic                        s_tx_tlast,

    // TX pass-through out
    output logic                        m_tx_tvalid,
    input  logic                        m_tx_tready,
    output logic [NET_DATA_BITS-1:0]    m_tx_tdata,
    output logic [NET_KEEP_BITS-1:0]    m_tx_tkeep,
    output logic                        m_tx_tlast,

    // FIFO occupancy for monitoring
    output logic [RX_FIFO_CNT_BITS-1:0] rx_fill
);

    // Filter to RX slices
    logic                     flt_tvalid;
    logic [NET_DATA_BITS-1:0] flt_tdata;
    logic [NET_KEEP_BITS-1:0] flt_tkeep;
    logic                     flt_tlast;

    // RX slices to FIFO
    logic                     arr_tvalid;
    logic                     arr_tready;
    logic [NET_DATA_BITS-1:0] arr_tdata;
    logic [NET_KEEP_BITS-1:0] arr_tkeep;
    logic                     arr_tlast;

    logic                     fifo_prog_full;

    net_bp_drop inst_drop (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .prog_full (fifo_prog_full),
        .s_tvalid  (s_rx_tvalid),
        .s_tdata   (s_rx_tdata),
        .s_tkeep   (s_rx_tkeep),
        .s_tlast   (s_rx_tlast),
        .m_tvalid  (flt_tvalid),
        .m_tdata   (flt_tdata),
        .m_tkeep   (flt_tkeep),
        .m_tlast   (flt_tlast)
    );

    // Filter output is a strobe, ready of the RX slices is not used
    axis_reg_array #(.N_STAGES(PIPE_STAGES)) inst_rx_array (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tvalid (flt_tvalid),
        .s_tready (),
        .s_tdata  (flt_tdata),
        .s_tkeep  (flt_tkeep),
        .s_tlast  (flt_tlast),
        .m_tvalid (arr_tvalid),
        .m_tready (arr_tready),
        .m_tdata  (arr_tdata),
        .m_tkeep  (arr_tkeep),
        .m_tlast  (arr_tlast)
    );

    net_rx_fifo inst_rx_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_tvalid  (arr_tvalid),
        .s_tready  (arr_tready),
        .s_tdata   (arr_tdata),
        .s_tkeep   (arr_tkeep),
        .s_tlast   (arr_tlast),
        .m_tvalid  (m_rx_tvalid),
        .m_tready  (m_rx_tready),
        .m_tdata   (m_rx_tdata),
        .m_tkeep   (m_rx_tkeep),
        .m_tlast   (m_rx_tlast),
        .fill      (rx_fill),
        .prog_full (fifo_prog_full)
    );

    // TX path, back-pressure comes from the sink
    axis_reg_array #(.N_STAGES(PIPE_STAGES)) inst_tx_array (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tvalid (s_tx_tvalid),
        .s_tready (s_tx_tready),
        .s_tdata  (s_tx_tdata),
        .s_tkeep  (s_tx_tkeep),
        .s_tlast  (s_tx_tlast),
        .m_tvalid (m_tx_tvalid),
        .m_tready (m_tx_tready),
        .m_tdata  (m_tx_tdata),
        .m_tkeep  (m_tx_tkeep),
        .m_tlast  (m_tx_tlast)
    );

endmodule

/* hw/net_pkg.sv */
// Network ingress shared definitions
// Beat layout, pipeline depth and RX FIFO sizing

package net_pkg;

    // Beat layout, one keep bit per data byte
    localparam int NET_DATA_BITS = 64;
    localparam int NET_KEEP_BITS = NET_DATA_BITS / 8;

    // Register stages in each slice array
    localparam int PIPE_STAGES = 2;

    // RX FIFO size in beats
    localparam int RX_FIFO_DEPTH = 64;

    // Fill count must reach RX_FIFO_DEPTH itself
    localparam int RX_FIFO_CNT_BITS = $clog2(RX_FIFO_DEPTH + 1);

    // Longest packet the network may send
    localparam int MAX_PKT_BEATS = 16;

    // Headroom for one whole packet plus beats still in the slices
    // and the one beat written on the edge where the flag is sampled
    localparam int PROG_FULL_LEVEL =
        RX_FIFO_DEPTH - MAX_PKT_BEATS - PIPE_STAGES - 1;

endpackage

/* hw/net_rx_fifo.sv */
// Receive beat FIFO between the RX slices and the host
// Circular buffer with fill count and programmable-full flag

`timescale 1ns/1ps

module net_rx_fifo import net_pkg::*; (
    input  logic                        aclk,
    input  logic                        aresetn,

    // Write side
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic [NET_DATA_BITS-1:0]    s_tdata,
    input  logic [NET_KEEP_BITS-1:0]    s_tkeep,
    input  logic                        s_tlast,

    // Read side
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic [NET_DATA_BITS-1:0]    m_tdata,
    output logic [NET_KEEP_BITS-1:0]    m_tkeep,
    output logic                        m_tlast,

    // Level reporting
    output logic [RX_FIFO_CNT_BITS-1:0] fill,
    output logic                        prog_full
);

    // Power-of-two depth, pointers wrap on their own
    logic [NET_DATA_BITS-1:0]         mem_data [RX_FIFO_DEPTH];
    logic [NET_KEEP_BITS-1:0]         mem_keep [RX_FIFO_DEPTH];
    logic                             mem_last [RX_FIFO_DEPTH];
    logic [$clog2(RX_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(RX_FIFO_DEPTH)-1:0] rd_ptr;
    logic                             wr_en;
    logic                             rd_en;

    assign s_tready = (fill != RX_FIFO_CNT_BITS'(RX_FIFO_DEPTH));
    assign m_tvalid = (fill != '0);
    assign wr_en    = s_tvalid && s_tready;
    assign rd_en    = m_tvalid && m_tready;

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= s_tdata;
            mem_keep[wr_ptr] <= s_tkeep;
            mem_last[wr_ptr] <= s_tlast;
        end
    end

    // Head of queue, visible the cycle after its write
    assign m_tdata = mem_data[rd_ptr];
    assign m_tkeep = mem_keep[rd_ptr];
    assign m_tlast = mem_last[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write keeps the count
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Drop filter threshold
    assign prog_full = (fill >= RX_FIFO_CNT_BITS'(PROG_FULL_LEVEL));

    // Upstream filter cannot stall, so the threshold must leave room
    a_no_overflow: assert property (
        @(posedge aclk) disable iff (!aresetn)
        s_tvalid |-> s_tready
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ingress testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_net_ingress \
    -f sim.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

/* sim.f */
hw/net_pkg.sv
hw/axis_reg_slice.sv
hw/axis_reg_array.sv
hw/net_bp_drop.sv
hw/net_rx_fifo.sv
hw/net_ingress_top.sv
testbench/clk_gen.sv
testbench/tb_net_ingress.sv

/* testbench/clk_gen.sv */
// Testbench clock and reset source
// 20 ns clock, synchronous active-low reset held for 4 cycles

`timescale 1ns/1ps

module clk_gen #(
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Release lines up with the 2 ns drive offset
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2 aresetn = 1'b1;
    end

endmodule

/* testbench/tb_net_ingress.sv */
// Testbench for the network ingress stage
// Packet table driven into RX and TX, scoreboards on both outputs

`timescale 1ns/1ps

module tb_net_ingress import net_pkg::*; ();

    localparam int BEAT_BITS = NET_DATA_BITS + NET_KEEP_BITS + 1;
    localparam int N_PKTS = 20;
    localparam logic [1:0] SINK_OPEN = 2'd0;
    localparam logic [1:0] SINK_HOLD = 2'd1;
    localparam logic [1:0] SINK_TOGGLE = 2'd2;

    typedef struct packed {
        logic [7:0] beats;
        logic       to_tx;
        logic [1:0] sink;
    } pkt_t;

    // Length, TX flag, sink ready mode
    pkt_t pkts [N_PKTS] = '{
        '{8'd1, 1'b0, SINK_OPEN}, '{8'd3, 1'b0, SINK_OPEN}, '{8'd16, 1'b0, SINK_OPEN},
        '{8'd8, 1'b0, SINK_OPEN}, '{8'd2, 1'b0, SINK_OPEN},
        // Fills to 45, then everything is dropped
        '{8'd16, 1'b0, SINK_HOLD}, '{8'd16, 1'b0, SINK_HOLD}, '{8'd10, 1'b0, SINK_HOLD},
        '{8'd1, 1'b0, SINK_HOLD}, '{8'd1, 1'b0, SINK_HOLD}, '{8'd1, 1'b0, SINK_HOLD},
        '{8'd1, 1'b0, SINK_HOLD}, '{8'd5, 1'b0, SINK_HOLD}, '{8'd16, 1'b0, SINK_HOLD},
        // Drain, then accepted again
        '{8'd4, 1'b0, SINK_OPEN}, '{8'd7, 1'b0, SINK_OPEN},
        '{8'd5, 1'b1, SINK_TOGGLE}, '{8'd16, 1'b1, SINK_TOGGLE},
        '{8'd1, 1'b1, SINK_TOGGLE}, '{8'd9, 1'b1, SINK_TOGGLE}
    };

    logic                        aclk;
    logic                        aresetn;
    logic                        s_rx_tvalid;
    logic [NET_DATA_BITS-1:0]    s_rx_tdata;
    logic [NET_KEEP_BITS-1:0]    s_rx_tkeep;
    logic                        s_rx_tlast;
    logic                        m_rx_tvalid;
    logic                        m_rx_tready;
    logic [NET_DATA_BITS-1:0]    m_rx_tdata;
    logic [NET_KEEP_BITS-1:0]    m_rx_tkeep;
    logic                        m_rx_tlast;
    logic                        s_tx_tvalid;
    logic                        s_tx_tready;
    logic [NET_DATA_BITS-1:0]    s_tx_tdata;
    logic [NET_KEEP_BITS-1:0]    s_tx_tkeep;
    logic                        s_tx_tlast;
    logic                        m_tx_tvalid;
    logic                        m_tx_tready;
    logic [NET_DATA_BITS-1:0]    m_tx_tdata;
    logic [NET_KEEP_BITS-1:0]    m_tx_tkeep;
    logic                        m_tx_tlast;
    logic [RX_FIFO_CNT_BITS-1:0] rx_fill;

    // Separate streams for beat content and TX sink ready
    logic [63:0] data_state = 64'd38;
    logic [63:0] ready_state = 64'd38;
    int n_errors = 0;
    int n_checks = 0;

    // Expected beats as {last, keep, data}
    logic [BEAT_BITS-1:0] exp_rx [$];
    logic [BEAT_BITS-1:0] exp_tx [$];

    clk_gen inst_clk (.aclk(aclk), .aresetn(aresetn));

    net_ingress_top dut0 (.*);

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic compare_beat(input string port, input logic [BEAT_BITS-1:0] want,
                                input logic [BEAT_BITS-1:0] got);
        check_value({port, " tdata"}, 64'(got[NET_DATA_BITS-1:0]),
                    64'(want[NET_DATA_BITS-1:0]));
        check_value({port, " tkeep"}, 64'(got[NET_DATA_BITS +: NET_KEEP_BITS]),
                    64'(want[NET_DATA_BITS +: NET_KEEP_BITS]));
        check_value({port, " tlast"}, 64'(got[BEAT_BITS-1]), 64'(want[BEAT_BITS-1]));
    endtask

    // All driving happens 2 ns after the rising edge
    task automatic next_cycle;
        @(posedge aclk);
        #2;
    endtask

    // Full keep, except a random partial last beat
    task automatic make_beat(input bit last, output logic [BEAT_BITS-1:0] beat);
        logic [NET_KEEP_BITS-1:0] keep;
        int n;
        data_state = xorshift64(data_state);
        n = 1 + int'(data_state[2:0]);
        keep = last ? NET_KEEP_BITS'((1 << n) - 1) : '1;
        data_state = xorshift64(data_state);
        beat = {last, keep, NET_DATA_BITS'(data_state)};
    endtask

    // Kept when fewer than PROG_FULL_LEVEL beats wait unread
    task automatic send_rx(input int beats, output bit kept);
        logic [BEAT_BITS-1:0] beat;
        kept = (exp_rx.size() < PROG_FULL_LEVEL);
        for (int b = 0; b < beats; b++) begin
            make_beat(b == beats - 1, beat);
            s_rx_tvalid = 1'b1;
            {s_rx_tlast, s_rx_tkeep, s_rx_tdata} = beat;
            if (kept) begin
                exp_rx.push_back(beat);
            end
            next_cycle();
        end
        s_rx_tvalid = 1'b0;
        s_rx_tlast = 1'b0;
        // Slices empty before the next first beat
        repeat (PIPE_STAGES + 2) next_cycle();
    endtask

    task automatic send_tx(input int beats);
        logic [BEAT_BITS-1:0] beat;
        bit taken;
        for (int b = 0; b < beats; b++) begin
            make_beat(b == beats - 1, beat);
            s_tx_tvalid = 1'b1;
            {s_tx_tlast, s_tx_tkeep, s_tx_tdata} = beat;
            taken = 1'b0;
            while (!taken) begin
                // Ready is settled mid-cycle
                @(negedge aclk);
                taken = s_tx_tready;
                if (taken) begin
                    exp_tx.push_back(beat);
                end
                next_cycle();
            end
        end
        s_tx_tvalid = 1'b0;
        s_tx_tlast = 1'b0;
        repeat (PIPE_STAGES + 2) next_cycle();
    endtask

    task automatic drain_rx;
        while (exp_rx.size() != 0) next_cycle();
        next_cycle();
        check_value("rx_fill after drain", 64'(rx_fill), 64'd0);
    endtask

    // TX sink ready follows the random sequence
    always @(posedge aclk) begin
        #2;
        ready_state = xorshift64(ready_state);
        m_tx_tready = ready_state[0];
    end

    always @(negedge aclk) begin : rx_monitor
        logic [BEAT_BITS-1:0] want;
        if (aresetn && m_rx_tvalid && m_rx_tready) begin
            if (exp_rx.size() == 0) begin
                $display("Error at %0t ns: RX output gave a beat with none pending", $time);
                n_errors++;
            end else begin
                want = exp_rx.pop_front();
                compare_beat("RX", want, {m_rx_tlast, m_rx_tkeep, m_rx_tdata});
            end
        end
    end

    always @(negedge aclk) begin : tx_monitor
        logic [BEAT_BITS-1:0] want;
        if (aresetn && m_tx_tvalid && m_tx_tready) begin
            if (exp_tx.size() == 0) begin
                $display("Error at %0t ns: TX output gave a beat with none pending", $time);
                n_errors++;
            end else begin
                want = exp_tx.pop_front();
                compare_beat("TX", want, {m_tx_tlast, m_tx_tkeep, m_tx_tdata});
            end
        end
    end

    initial begin
        bit kept;
        logic [1:0] prev_sink;
        s_rx_tvalid = 1'b0;
        s_rx_tdata = '0;
        s_rx_tkeep = '0;
        s_rx_tlast = 1'b0;
        s_tx_tvalid = 1'b0;
        s_tx_tdata = '0;
        s_tx_tkeep = '0;
        s_tx_tlast = 1'b0;
        m_rx_tready = 1'b1;
        m_tx_tready = 1'b0;
        prev_sink = SINK_OPEN;
        @(posedge aresetn);
        @(negedge aclk);
        check_value("m_rx_tvalid after reset", 64'(m_rx_tvalid), 64'd0);
        check_value("m_tx_tvalid after reset", 64'(m_tx_tvalid), 64'd0);
        check_value("rx_fill after reset", 64'(rx_fill), 64'd0);
        $display("Reset check done, errors so far %0d", n_errors);
        next_cycle();
        for (int i = 0; i < N_PKTS; i++) begin
            if (!pkts[i].to_tx) begin
                // Sink reopened, held packets must drain first
                if (pkts[i].sink == SINK_OPEN && prev_sink == SINK_HOLD) begin
                    m_rx_tready = 1'b1;
                    drain_rx();
                end
                m_rx_tready = (pkts[i].sink != SINK_HOLD);
                prev_sink = pkts[i].sink;
                send_rx(int'(pkts[i].beats), kept);
                if (pkts[i].sink == SINK_HOLD) begin
                    check_value("rx_fill", 64'(rx_fill), 64'(exp_rx.size()));
                end
                $display("Packet %0d: RX, %0d beats, %s, errors so far %0d",
                         i, pkts[i].beats, kept ? "kept" : "dropped", n_errors);
            end else begin
                send_tx(int'(pkts[i].beats));
                $display("Packet %0d: TX, %0d beats, errors so far %0d",
                         i, pkts[i].beats, n_errors);
            end
        end
        m_rx_tready = 1'b1;
        drain_rx();
        while (exp_tx.size() != 0) next_cycle();
        // Room for any stray extra beat to show up
        repeat (PIPE_STAGES + 4) next_cycle();
        $display("Summary: %0d packets, %0d checks, %0d errors", N_PKTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Limit scales with the table length
    initial begin
        int total;
        total = 0;
        for (int i = 0; i < N_PKTS; i++) begin
            total += int'(pkts[i].beats);
        end
        repeat (total * 40 + 1000) @(posedge aclk);
        $display("Timeout: run did not finish within %0d cycles", total * 40 + 1000);
        $display("TEST FAILED");
        $finish;
    end

endmodule
